// ==== design/merge_pkg.sv ====
package merge_pkg;

   localparam int KEY_W = 32;
   localparam int PAYLOAD_W = 32;
   localparam int REC_W = KEY_W + PAYLOAD_W;

   typedef logic [KEY_W-1:0] key_t;
   typedef logic [PAYLOAD_W-1:0] payload_t;

   // key sits in the low half so comparisons look at bits 31:0
   typedef logic [REC_W-1:0] record_t;

   // a zero key closes a run, real keys are never zero
   localparam key_t TERM_KEY = '0;
   localparam record_t TERM_REC = {payload_t'(0), TERM_KEY};

   // default sizes, depth must be a power of two
   localparam int DEF_N_LANES = 4;
   localparam int DEF_FIFO_DEPTH = 16;

   function automatic key_t rec_key(input record_t rec);
      return rec[KEY_W-1:0];
   endfunction

   function automatic logic is_term(input record_t rec);
      return rec_key(rec) == TERM_KEY;
   endfunction

endpackage

// ==== design/run_pair_if.sv ====
`timescale 1ns/100ps

interface run_pair_if;

   // stream A side of one pair
   merge_pkg::record_t a_rec;
   logic               a_push;
   logic               a_full;

   // stream B side of one pair
   merge_pkg::record_t b_rec;
   logic               b_push;
   logic               b_full;

   modport dispatch (
      output a_rec, a_push, b_rec, b_push,
      input  a_full, b_full
   );

   modport lane (
      input  a_rec, a_push, b_rec, b_push,
      output a_full, b_full
   );

endinterface

// ==== design/lane_fifo.sv ====
`timescale 1ns/100ps

module lane_fifo #(
   parameter int DEPTH = merge_pkg::DEF_FIFO_DEPTH
) (
   input  logic               i_clk,
   input  logic               i_rst_n,
   input  merge_pkg::record_t i_data,
   input  logic               i_enq,
   input  logic               i_deq,
   output merge_pkg::record_t o_data,
   output logic               o_empty,
   output logic               o_full
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   merge_pkg::record_t mem [DEPTH];

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;
   logic          do_enq;
   logic          do_deq;

   assign do_enq = i_enq && !o_full;
   assign do_deq = i_deq && !o_empty;

   // first word falls through
   assign o_data  = mem[rd_ptr];
   assign o_empty = (count == '0);
   assign o_full  = (count == (AW + 1)'(DEPTH));

   always_ff @(posedge i_clk) begin
      if (do_enq) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_enq) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_deq) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         // pointers wrap naturally since depth is a power of two
         case ({do_enq, do_deq})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== design/merge_lane.sv ====
`timescale 1ns/100ps

module merge_lane #(
   parameter int FIFO_DEPTH = merge_pkg::DEF_FIFO_DEPTH
) (
   input  logic               i_clk,
   input  logic               i_rst_n,
   run_pair_if.lane           pair,
   output merge_pkg::record_t o_out_rec,
   output logic               o_out_empty,
   input  logic               i_out_pop
);

   typedef enum logic {
      ST_MERGE,
      ST_FLUSH
   } state_t;

   state_t             state;
   state_t             next_state;
   merge_pkg::record_t a_head;
   merge_pkg::record_t b_head;
   merge_pkg::key_t    a_key;
   merge_pkg::key_t    b_key;
   logic               a_empty;
   logic               b_empty;
   logic               a_term;
   logic               b_term;
   logic               take_a;
   logic               take_b;
   logic               load;
   merge_pkg::record_t sel_rec;
   merge_pkg::record_t out_reg;
   logic               out_vld;
   logic               out_full;
   logic               advance;

   lane_fifo #(.DEPTH(FIFO_DEPTH)) fifo_a (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_data  (pair.a_rec),
      .i_enq   (pair.a_push),
      .i_deq   (take_a),
      .o_data  (a_head),
      .o_empty (a_empty),
      .o_full  (pair.a_full)
   );

   lane_fifo #(.DEPTH(FIFO_DEPTH)) fifo_b (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_data  (pair.b_rec),
      .i_enq   (pair.b_push),
      .i_deq   (take_b),
      .o_data  (b_head),
      .o_empty (b_empty),
      .o_full  (pair.b_full)
   );

   lane_fifo #(.DEPTH(FIFO_DEPTH)) fifo_out (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_data  (out_reg),
      .i_enq   (out_vld && !out_full),
      .i_deq   (i_out_pop),
      .o_data  (o_out_rec),
      .o_empty (o_out_empty),
      .o_full  (out_full)
   );

   assign a_key  = merge_pkg::rec_key(a_head);
   assign b_key  = merge_pkg::rec_key(b_head);
   assign a_term = merge_pkg::is_term(a_head);
   assign b_term = merge_pkg::is_term(b_head);

   // register is free, or its record drains into fifo_out this cycle
   assign advance = !out_vld || !out_full;

   // compare-select, both heads must be present before anything moves
   always_comb begin
      next_state = state;
      take_a     = 1'b0;
      take_b     = 1'b0;
      load       = 1'b0;
      sel_rec    = a_head;
      if (advance) begin
         case (state)
            ST_MERGE: begin
               if (!a_empty && !b_empty) begin
                  if (a_term && b_term) begin
                     take_a     = 1'b1;
                     take_b     = 1'b1;
                     next_state = ST_FLUSH;
                  end else if (b_term || (!a_term && a_key <= b_key)) begin
                     // ties go to A so the merge stays stable
                     take_a = 1'b1;
                     load   = 1'b1;
                  end else begin
                     take_b  = 1'b1;
                     load    = 1'b1;
                     sel_rec = b_head;
                  end
               end
            end
            ST_FLUSH: begin
               load       = 1'b1;
               sel_rec    = merge_pkg::TERM_REC;
               next_state = ST_MERGE;
            end
            default: next_state = ST_MERGE;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (load) begin
         out_reg <= sel_rec;
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state   <= ST_MERGE;
         out_vld <= 1'b0;
      end else begin
         state <= next_state;
         if (load) begin
            out_vld <= 1'b1;
         end else if (!out_full) begin
            out_vld <= 1'b0;
         end
      end
   end

endmodule

// ==== design/run_dispatcher.sv ====
`timescale 1ns/100ps

module run_dispatcher #(
   parameter int N_LANES = merge_pkg::DEF_N_LANES
) (
   input  logic               i_clk,
   input  logic               i_rst_n,
   input  merge_pkg::record_t i_a_rec,
   input  logic               i_a_empty,
   output logic               o_a_read,
   input  merge_pkg::record_t i_b_rec,
   input  logic               i_b_empty,
   output logic               o_b_read,
   run_pair_if.dispatch       lanes [N_LANES]
);

   localparam int LW = (N_LANES > 1) ? $clog2(N_LANES) : 1;

   logic [LW-1:0]      a_ptr;
   logic [LW-1:0]      b_ptr;
   logic [N_LANES-1:0] a_full_vec;
   logic [N_LANES-1:0] b_full_vec;

   // interface arrays need constant indices, so fan out per lane
   for (genvar i = 0; i < N_LANES; i++) begin : g_lane
      assign a_full_vec[i]  = lanes[i].a_full;
      assign b_full_vec[i]  = lanes[i].b_full;
      assign lanes[i].a_rec  = i_a_rec;
      assign lanes[i].b_rec  = i_b_rec;
      assign lanes[i].a_push = o_a_read && (a_ptr == LW'(i));
      assign lanes[i].b_push = o_b_read && (b_ptr == LW'(i));
   end

   assign o_a_read = !i_a_empty && !a_full_vec[a_ptr];
   assign o_b_read = !i_b_empty && !b_full_vec[b_ptr];

   // each stream moves to the next lane once its terminator is through,
   // A and B keep their own pointers so either side may run ahead
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         a_ptr <= '0;
         b_ptr <= '0;
      end else begin
         if (o_a_read && merge_pkg::is_term(i_a_rec)) begin
            if (a_ptr == LW'(N_LANES - 1)) begin
               a_ptr <= '0;
            end else begin
               a_ptr <= a_ptr + 1'b1;
            end
         end
         if (o_b_read && merge_pkg::is_term(i_b_rec)) begin
            if (b_ptr == LW'(N_LANES - 1)) begin
               b_ptr <= '0;
            end else begin
               b_ptr <= b_ptr + 1'b1;
            end
         end
      end
   end

endmodule

// ==== design/run_collector.sv ====
`timescale 1ns/100ps

module run_collector #(
   parameter int N_LANES = merge_pkg::DEF_N_LANES
) (
   input  logic                              i_clk,
   input  logic                              i_rst_n,
   input  merge_pkg::record_t [N_LANES-1:0]  i_lane_rec,
   input  logic [N_LANES-1:0]                i_lane_empty,
   output logic [N_LANES-1:0]                o_lane_pop,
   input  logic                              i_out_ready,
   output merge_pkg::record_t                o_out_rec,
   output logic                              o_out_write
);

   localparam int LW = (N_LANES > 1) ? $clog2(N_LANES) : 1;

   logic [LW-1:0] ptr;
   logic          last_of_run;

   // current lane head goes straight out
   assign o_out_rec   = i_lane_rec[ptr];
   assign o_out_write = i_out_ready && i_rst_n && !i_lane_empty[ptr];
   assign last_of_run = merge_pkg::is_term(o_out_rec);

   for (genvar i = 0; i < N_LANES; i++) begin : g_pop
      assign o_lane_pop[i] = o_out_write && (ptr == LW'(i));
   end

   // stay on one lane for a whole run, then step round-robin
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         ptr <= '0;
      end else if (o_out_write && last_of_run) begin
         if (ptr == LW'(N_LANES - 1)) begin
            ptr <= '0;
         end else begin
            ptr <= ptr + 1'b1;
         end
      end
   end

endmodule

// ==== design/parallel_run_merger.sv ====
`timescale 1ns/100ps

module parallel_run_merger #(
   parameter int N_LANES    = merge_pkg::DEF_N_LANES,
   parameter int FIFO_DEPTH = merge_pkg::DEF_FIFO_DEPTH
) (
   input  logic               i_clk,
   input  logic               i_rst_n,
   // upstream stream A
   input  merge_pkg::record_t i_a_rec,
   input  logic               i_a_empty,
   output logic               o_a_read,
   // upstream stream B
   input  merge_pkg::record_t i_b_rec,
   input  logic               i_b_empty,
   output logic               o_b_read,
   // merged output
   input  logic               i_out_ready,
   output merge_pkg::record_t o_out_rec,
   output logic               o_out_write
);

   merge_pkg::record_t [N_LANES-1:0] lane_rec;
   logic [N_LANES-1:0]               lane_empty;
   logic [N_LANES-1:0]               lane_pop;

   run_pair_if pair_if [N_LANES] ();

   run_dispatcher #(
      .N_LANES (N_LANES)
   ) run_dispatcher_inst (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_a_rec   (i_a_rec),
      .i_a_empty (i_a_empty),
      .o_a_read  (o_a_read),
      .i_b_rec   (i_b_rec),
      .i_b_empty (i_b_empty),
      .o_b_read  (o_b_read),
      .lanes     (pair_if)
   );

   // pair k lands in lane k mod N_LANES
   for (genvar i = 0; i < N_LANES; i++) begin : g_lane
      merge_lane #(
         .FIFO_DEPTH (FIFO_DEPTH)
      ) merge_lane_inst (
         .i_clk       (i_clk),
         .i_rst_n     (i_rst_n),
         .pair        (pair_if[i]),
         .o_out_rec   (lane_rec[i]),
         .o_out_empty (lane_empty[i]),
         .i_out_pop   (lane_pop[i])
      );
   end

   run_collector #(
      .N_LANES (N_LANES)
   ) run_collector_inst (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_lane_rec   (lane_rec),
      .i_lane_empty (lane_empty),
      .o_lane_pop   (lane_pop),
      .i_out_ready  (i_out_ready),
      .o_out_rec    (o_out_rec),
      .o_out_write  (o_out_write)
   );

endmodule

// ==== tb/tb_parallel_run_merger.sv ====
`timescale 1ns/100ps

module tb_parallel_run_merger;

   localparam int N_LANES = 4;
   localparam int FIFO_DEPTH = 16;
   localparam int N_PAIRS = 40;
   localparam int RESET_CYCLES = 10;
   localparam int DRAIN_CYCLES = 20;
   localparam int STALL_PERIOD = 400;
   localparam int STALL_CYCLES = 150;
   localparam logic [31:0] SEED = 32'hac31_f6c0;
   // zero key with zero payload closes every run
   localparam merge_pkg::record_t END_OF_RUN = 64'd0;

   logic               i_clk;
   logic               i_rst_n;
   merge_pkg::record_t i_a_rec;
   logic               i_a_empty;
   logic               o_a_read;
   merge_pkg::record_t i_b_rec;
   logic               i_b_empty;
   logic               o_b_read;
   logic               i_out_ready;
   merge_pkg::record_t o_out_rec;
   logic               o_out_write;

   logic [31:0]        lfsr_state;
   merge_pkg::record_t a_q[$];
   merge_pkg::record_t b_q[$];
   merge_pkg::record_t exp_q[$];
   merge_pkg::record_t run_a[$];
   merge_pkg::record_t run_b[$];
   int                 edge_cnt;
   int                 cycle_limit;
   int                 drain;
   int                 a_runs;
   int                 b_runs;
   int                 max_lead;
   logic               a_taken;
   logic               b_taken;
   logic               out_seen;
   logic               ready_seen;

   parallel_run_merger #(
      .N_LANES    (N_LANES),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) parallel_run_merger_inst (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_a_rec     (i_a_rec),
      .i_a_empty   (i_a_empty),
      .o_a_read    (o_a_read),
      .i_b_rec     (i_b_rec),
      .i_b_empty   (i_b_empty),
      .o_b_read    (o_b_read),
      .i_out_ready (i_out_ready),
      .o_out_rec   (o_out_rec),
      .o_out_write (o_out_write)
   );

   initial begin
      i_clk = 1'b0;
      forever #20 i_clk = ~i_clk;
   end

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   // small key steps so ties inside and across runs are common
   task automatic add_run(input int len, input logic to_a);
      logic [31:0] key;
      key = 32'd1 + rand_bits(3);
      for (int i = 0; i < len; i++) begin
         if (to_a) begin
            run_a.push_back({rand_bits(32), key});
         end else begin
            run_b.push_back({rand_bits(32), key});
         end
         key = key + rand_bits(2);
      end
   endtask

   task automatic merge_runs();
      int                 i;
      int                 j;
      logic               take_a;
      merge_pkg::record_t rec_a;
      merge_pkg::record_t rec_b;
      i = 0;
      j = 0;
      while (i < run_a.size() || j < run_b.size()) begin
         if (j == run_b.size()) begin
            take_a = 1'b1;
         end else if (i == run_a.size()) begin
            take_a = 1'b0;
         end else begin
            rec_a = run_a[i];
            rec_b = run_b[j];
            // A wins ties to keep the merge stable
            take_a = (rec_a[31:0] <= rec_b[31:0]);
         end
         if (take_a) begin
            exp_q.push_back(run_a[i]);
            i++;
         end else begin
            exp_q.push_back(run_b[j]);
            j++;
         end
      end
      exp_q.push_back(END_OF_RUN);
   endtask

   task automatic build_stimulus();
      int len_a;
      int len_b;
      for (int k = 0; k < N_PAIRS; k++) begin
         len_a = int'(rand_bits(4) % 32'd10);
         len_b = int'(rand_bits(4) % 32'd10);
         // pairs 1 to 3 cover one empty side and both sides empty
         if (k == 1) begin
            len_a = 0;
            len_b = len_b + 1;
         end
         if (k == 2) begin
            len_a = len_a + 1;
            len_b = 0;
         end
         if (k == 3) begin
            len_a = 0;
            len_b = 0;
         end
         run_a.delete();
         run_b.delete();
         add_run(len_a, 1'b1);
         add_run(len_b, 1'b0);
         foreach (run_a[i]) a_q.push_back(run_a[i]);
         a_q.push_back(END_OF_RUN);
         foreach (run_b[i]) b_q.push_back(run_b[i]);
         b_q.push_back(END_OF_RUN);
         merge_runs();
      end
   endtask

   // sampled mid-cycle when all DUT outputs have settled
   task automatic check_cycle();
      merge_pkg::record_t want;
      a_taken    = o_a_read;
      b_taken    = o_b_read;
      out_seen   = o_out_write;
      ready_seen = i_out_ready;
      if (edge_cnt <= RESET_CYCLES) begin
         assert (!o_out_write) else report_failure(
            $sformatf("** Error at %0t: output write in or right after reset", $time));
      end
      assert (!(o_a_read && i_a_empty)) else report_failure(
         $sformatf("** Error at %0t: stream A read while empty", $time));
      assert (!(o_b_read && i_b_empty)) else report_failure(
         $sformatf("** Error at %0t: stream B read while empty", $time));
      assert (!(o_out_write && !i_out_ready)) else report_failure(
         $sformatf("** Error at %0t: output write while not ready", $time));
      if (o_out_write) begin
         assert (exp_q.size() != 0) else report_failure(
            $sformatf("** Error at %0t: extra output record %h", $time, o_out_rec));
         want = exp_q.pop_front();
         assert (o_out_rec == want) else report_failure(
            $sformatf("** Error at %0t: output %h, expected %h", $time, o_out_rec, want));
      end
      if (o_a_read && i_a_rec[31:0] == 32'd0) a_runs++;
      if (o_b_read && i_b_rec[31:0] == 32'd0) b_runs++;
      if (a_runs - b_runs > max_lead) max_lead = a_runs - b_runs;
   endtask

   task automatic drive_inputs();
      logic gate_a;
      logic gate_b;
      logic ready_bit;
      if (a_taken) void'(a_q.pop_front());
      if (b_taken) void'(b_q.pop_front());
      gate_a    = (rand_bits(2) != 32'd0);
      gate_b    = (rand_bits(2) == 32'd3);
      ready_bit = (rand_bits(2) != 32'd0);
      if (edge_cnt >= RESET_CYCLES) i_rst_n = 1'b1;
      if (i_rst_n) begin
         // B is offered far less often so A gets whole runs ahead
         i_a_empty   = !(a_q.size() != 0 && gate_a);
         i_b_empty   = !(b_q.size() != 0 && gate_b);
         // long stalls let the lane FIFOs fill up and push back on the inputs
         i_out_ready = ready_bit && (edge_cnt % STALL_PERIOD < STALL_PERIOD - STALL_CYCLES);
      end
      i_a_rec = (a_q.size() != 0) ? a_q[0] : '0;
      i_b_rec = (b_q.size() != 0) ? b_q[0] : '0;
   endtask

   initial begin
      i_rst_n     = 1'b0;
      i_a_rec     = '0;
      i_a_empty   = 1'b1;
      i_b_rec     = '0;
      i_b_empty   = 1'b1;
      i_out_ready = 1'b1;
      lfsr_state  = SEED;
      edge_cnt    = 0;
      drain       = 0;
      a_runs      = 0;
      b_runs      = 0;
      max_lead    = 0;
      a_taken     = 1'b0;
      b_taken     = 1'b0;
      out_seen    = 1'b0;
      ready_seen  = 1'b0;
      build_stimulus();
      cycle_limit = 60 * exp_q.size() + 2000;
      while (drain < DRAIN_CYCLES) begin
         @(negedge i_clk);
         check_cycle();
         @(posedge i_clk);
         edge_cnt++;
         #2;
         drive_inputs();
         if (edge_cnt > cycle_limit) begin
            report_failure($sformatf("timeout, merged output not complete in %0d cycles",
               cycle_limit));
         end
         // once all input is taken the output has to go quiet while ready is high
         if (i_rst_n && a_q.size() == 0 && b_q.size() == 0) begin
            if (out_seen) begin
               drain = 0;
            end else if (ready_seen) begin
               drain++;
            end
         end
      end
      assert (max_lead >= 2) else report_failure(
         $sformatf("** Error at %0t: stream A led stream B by only %0d runs", $time, max_lead));
      if (exp_q.size() == 0) begin
         $display("STATUS: PASS");
         $finish;
      end else begin
         report_failure($sformatf("%0d expected records never came out", exp_q.size()));
      end
   end

endmodule

// ==== filelist.f ====
design/merge_pkg.sv
design/run_pair_if.sv
design/lane_fifo.sv
design/merge_lane.sv
design/run_dispatcher.sv
design/run_collector.sv
design/parallel_run_merger.sv
tb/tb_parallel_run_merger.sv

// ==== Makefile ====
# Verilator build and run of the parallel run merger testbench

VERILATOR ?= verilator
TOP       ?= tb_parallel_run_merger
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard design/*.sv tb/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# a $$fatal in the testbench makes the binary exit nonzero
test: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
